//--- fb_pkg.sv
`default_nettype none

package fb_pkg;

   // horizontal timing in pixel periods
   localparam int H_ACTIVE = 640;
   localparam int H_FRONT  = 16;
   localparam int H_SYNC   = 96;
   localparam int H_BACK   = 48;
   localparam int H_TOTAL  = 800;

   // vertical timing in lines
   localparam int V_ACTIVE = 480;
   localparam int V_FRONT  = 10;
   localparam int V_SYNC   = 2;
   localparam int V_BACK   = 33;
   localparam int V_TOTAL  = 525;

   localparam int H_CNT_W  = 10;     // holds 0 .. H_TOTAL-1
   localparam int V_CNT_W  = 10;     // holds 0 .. V_TOTAL-1

   // stored image, upscaled 5x on the display
   localparam int IMG_W    = 128;
   localparam int IMG_H    = 96;
   localparam int SCALE    = 5;
   localparam int PH_W     = 3;      // phase counter width, holds 0 .. SCALE-1

   localparam int ADDR_W   = 14;     // row * IMG_W + col

   typedef logic [ADDR_W-1:0] fb_addr_t;

   // one bit per colour plane, red in the msb
   typedef struct packed {
      logic red;
      logic green;
      logic blue;
   } rgb_t;

endpackage

`default_nettype wire

//--- video_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if;

   logic h_sync;        // active low
   logic v_sync;        // active low
   logic active;        // inside the 640x480 area
   logic line_start;    // h count 0
   logic frame_start;   // h count 0 of line 0

   modport source (
      output h_sync,
      output v_sync,
      output active,
      output line_start,
      output frame_start
   );

   modport sink (
      input h_sync,
      input v_sync,
      input active,
      input line_start,
      input frame_start
   );

endinterface

`default_nettype wire

//--- color_plane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module color_plane_ram
   import fb_pkg::*;
(
   input  logic     clk,
   input  logic     rd_en,
   input  fb_addr_t rd_addr,
   output logic     rd_data,
   input  logic     wr_en,
   input  fb_addr_t wr_addr,
   input  logic     wr_data
);

   // 16K x 1, enough for the 128x96 plane with room to spare
   logic mem [0:(1 << ADDR_W)-1] = '{default: 1'b0};

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // a read that collides with a write sees the old bit
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

//--- vga_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen
   import fb_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   video_timing_if.source        vt
);

   logic [H_CNT_W-1:0] h_cnt;
   logic [V_CNT_W-1:0] v_cnt;

   logic h_last;
   logic v_last;
   logic h_sync_n;
   logic v_sync_n;
   logic in_active;

   assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
   assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

   // sync pulse sits after the front porch
   assign h_sync_n = !((h_cnt >= H_CNT_W'(H_ACTIVE + H_FRONT)) &&
                       (h_cnt <  H_CNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));
   assign v_sync_n = !((v_cnt >= V_CNT_W'(V_ACTIVE + V_FRONT)) &&
                       (v_cnt <  V_CNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));

   assign in_active = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // outputs describe the count one cycle later
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vt.h_sync      <= 1'b1;     // syncs idle high
         vt.v_sync      <= 1'b1;
         vt.active      <= 1'b0;
         vt.line_start  <= 1'b0;
         vt.frame_start <= 1'b0;
      end else begin
         vt.h_sync      <= h_sync_n;
         vt.v_sync      <= v_sync_n;
         vt.active      <= in_active;
         vt.line_start  <= (h_cnt == '0);
         vt.frame_start <= (h_cnt == '0) && (v_cnt == '0);
      end
   end

   a_h_cnt_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      h_cnt < H_CNT_W'(H_TOTAL)
   );

endmodule

`default_nettype wire

//--- pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch
   import fb_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   video_timing_if.sink      vt,
   output logic              rd_en,
   output fb_addr_t          rd_addr,
   input  rgb_t              plane_data,
   output logic              hsync,
   output logic              vsync,
   output logic              de,
   output rgb_t              pix
);

   logic [PH_W-1:0]          col_ph_q;
   logic [PH_W-1:0]          col_ph_cur;
   logic [PH_W-1:0]          row_ph_q;
   logic [PH_W-1:0]          row_ph_cur;
   logic [$clog2(IMG_W)-1:0] col_q;
   logic [$clog2(IMG_W)-1:0] col_cur;
   logic [$clog2(IMG_H)-1:0] row_q;
   logic [$clog2(IMG_H)-1:0] row_cur;

   logic [2:0] ctl_d1;   // {h_sync, v_sync, active} beside the address
   logic [2:0] ctl_d2;   // beside the ram read

   // position of the pixel the interface shows right now
   always_comb begin
      col_ph_cur = col_ph_q;
      col_cur    = col_q;
      row_ph_cur = row_ph_q;
      row_cur    = row_q;
      if (vt.line_start) begin
         col_ph_cur = '0;
         col_cur    = '0;
         if (row_ph_q == PH_W'(SCALE - 1)) begin
            row_ph_cur = '0;
            row_cur    = row_q + 1'b1;
         end else begin
            row_ph_cur = row_ph_q + 1'b1;
         end
      end
      if (vt.frame_start) begin
         row_ph_cur = '0;
         row_cur    = '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         col_ph_q <= '0;
         col_q    <= '0;
         row_ph_q <= '0;
         row_q    <= '0;
      end else begin
         if (col_ph_cur == PH_W'(SCALE - 1)) begin
            col_ph_q <= '0;
            col_q    <= col_cur + 1'b1;   // wraps harmlessly in blanking
         end else begin
            col_ph_q <= col_ph_cur + 1'b1;
            col_q    <= col_cur;
         end
         row_ph_q <= row_ph_cur;
         row_q    <= row_cur;
      end
   end

   // stage 1 address, stage 2 ram, stage 3 output
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_en   <= 1'b0;
         rd_addr <= '0;
         ctl_d1  <= 3'b110;
         ctl_d2  <= 3'b110;
         hsync   <= 1'b1;
         vsync   <= 1'b1;
         de      <= 1'b0;
         pix     <= '0;
      end else begin
         rd_en   <= vt.active;
         rd_addr <= {row_cur, col_cur};
         ctl_d1  <= {vt.h_sync, vt.v_sync, vt.active};
         ctl_d2  <= ctl_d1;
         hsync   <= ctl_d2[2];
         vsync   <= ctl_d2[1];
         de      <= ctl_d2[0];
         pix     <= ctl_d2[0] ? plane_data : '0;   // black outside the active area
      end
   end

   a_phase_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      (col_ph_q < PH_W'(SCALE)) && (row_ph_q < PH_W'(SCALE))
   );

   a_addr_in_image : assert property (
      @(posedge clk) disable iff (!arst_n)
      rd_en |-> (rd_addr < ADDR_W'(IMG_W * IMG_H))
   );

endmodule

`default_nettype wire

//--- fb_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module fb_write_port
   import fb_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       wr_en,
   input  logic [7:0] wr_x,
   input  logic [6:0] wr_y,
   input  rgb_t       wr_rgb,
   input  rgb_t       wr_mask,
   output fb_addr_t   ram_addr,
   output rgb_t       ram_we,
   output rgb_t       ram_data
);

   logic in_range;

   assign in_range = (wr_x < 8'(IMG_W)) && (wr_y < 7'(IMG_H));

   // per-plane enables, dropped writes become all zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ram_we <= '0;
      end else if (wr_en && in_range) begin
         ram_we <= wr_mask;
      end else begin
         ram_we <= '0;
      end
   end

   always_ff @(posedge clk) begin
      ram_addr <= {wr_y, wr_x[6:0]};   // row * 128 + col
      ram_data <= wr_rgb;
   end

   a_drop_out_of_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      (wr_en && !in_range) |=> (ram_we == '0)
   );

endmodule

`default_nettype wire

//--- frame_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top
   import fb_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       wr_en,
   input  logic [7:0] wr_x,
   input  logic [6:0] wr_y,
   input  logic [2:0] wr_rgb,     // {red, green, blue}
   input  logic [2:0] wr_mask,
   output logic       hsync,
   output logic       vsync,
   output logic       de,
   output logic       red,
   output logic       green,
   output logic       blue
);

   fb_addr_t ram_addr;
   rgb_t     ram_we;
   rgb_t     ram_data;

   logic     rd_en;
   fb_addr_t rd_addr;
   logic     red_rd;
   logic     green_rd;
   logic     blue_rd;

   video_timing_if vt ();

   fb_write_port u_write_port (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_en    (wr_en),
      .wr_x     (wr_x),
      .wr_y     (wr_y),
      .wr_rgb   (wr_rgb),
      .wr_mask  (wr_mask),
      .ram_addr (ram_addr),
      .ram_we   (ram_we),
      .ram_data (ram_data)
   );

   color_plane_ram u_ram_red (
      .clk     (clk),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (red_rd),
      .wr_en   (ram_we.red),
      .wr_addr (ram_addr),
      .wr_data (ram_data.red)
   );

   color_plane_ram u_ram_green (
      .clk     (clk),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (green_rd),
      .wr_en   (ram_we.green),
      .wr_addr (ram_addr),
      .wr_data (ram_data.green)
   );

   color_plane_ram u_ram_blue (
      .clk     (clk),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (blue_rd),
      .wr_en   (ram_we.blue),
      .wr_addr (ram_addr),
      .wr_data (ram_data.blue)
   );

   vga_timing_gen u_timing (
      .clk    (clk),
      .arst_n (arst_n),
      .vt     (vt.source)
   );

   pixel_fetch u_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .vt         (vt.sink),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .plane_data ({red_rd, green_rd, blue_rd}),
      .hsync      (hsync),
      .vsync      (vsync),
      .de         (de),
      .pix        ({red, green, blue})
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   localparam int HALF_PERIOD_NS = 2;   // 4 ns clock
   localparam int RESET_CYCLES   = 8;

   initial begin
      clk = 1'b0;
      forever begin
         #HALF_PERIOD_NS clk = ~clk;
      end
   end

   initial begin
      arst_n = 1'b0;                     // low from time zero
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;                    // released on a rising edge
   end

endmodule

`default_nettype wire

//--- tb_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_buffer
   import fb_pkg::*;
();

   localparam int CHECK_LINES = 20;          // only the top of each frame is compared
   localparam int MAX_CYCLES  = 1_400_000;   // frame 0 plus three checked frames, with margin

   logic       clk;
   logic       arst_n;
   logic       wr_en;
   logic [7:0] wr_x;
   logic [6:0] wr_y;
   rgb_t       wr_rgb;
   rgb_t       wr_mask;
   logic       hsync;
   logic       vsync;
   logic       de;
   logic       red;
   logic       green;
   logic       blue;

   rgb_t        model [0:IMG_H-1][0:IMG_W-1];   // reference image
   int unsigned seed = 24262;
   int          errors = 0;
   int unsigned cycle_count = 0;
   int          written_x [$];                   // pixels touched by the pattern test
   int          written_y [$];

   tb_clock_gen u_clock (.clk(clk), .arst_n(arst_n));

   frame_buffer_top dut (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (wr_en),
      .wr_x    (wr_x),
      .wr_y    (wr_y),
      .wr_rgb  (wr_rgb),
      .wr_mask (wr_mask),
      .hsync   (hsync),
      .vsync   (vsync),
      .de      (de),
      .red     (red),
      .green   (green),
      .blue    (blue)
   );

   function automatic int unsigned next_random();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 8;                          // low bits of an lcg are weak
   endfunction

   task automatic report_mismatch(input string test, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
      errors++;
      $display("** Error %s: %s expected %0d, actual %0d", test, what, expected, actual);
   endtask

   task automatic write_pixel(input logic [7:0] x, input logic [6:0] y,
                              input rgb_t rgb, input rgb_t mask);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_x    <= x;
      wr_y    <= y;
      wr_rgb  <= rgb;
      wr_mask <= mask;
      if (x < IMG_W && y < IMG_H) begin
         model[y][x] = (model[y][x] & ~mask) | (rgb & mask);   // unmasked planes keep their bit
      end
   endtask

   task automatic end_writes();
      @(posedge clk);
      wr_en <= 1'b0;
   endtask

   task automatic wait_vsync_fall();
      @(posedge clk);
      while (vsync) begin
         @(posedge clk);
      end
   endtask

   task automatic check_idle(input string test);
      if (hsync !== 1'b1) report_mismatch(test, "hsync", 1, hsync);
      if (vsync !== 1'b1) report_mismatch(test, "vsync", 1, vsync);
      if (de !== 1'b0) report_mismatch(test, "de", 0, de);
      if ({red, green, blue} !== 3'b000) report_mismatch(test, "rgb", 0, {red, green, blue});
   endtask

   // follows the outputs from vertical blanking through the first checked lines
   task automatic check_lines(input string test);
      int   x;
      int   y;
      logic de_q;
      bit   done;
      rgb_t got;
      rgb_t expected;
      x    = 0;
      y    = -1;
      de_q = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         got = {red, green, blue};
         if (de) begin
            if (!de_q) begin
               y++;                              // new de run, next display line
               x = 0;
            end
            expected = model[y / SCALE][x / SCALE];
            if (got !== expected) begin
               report_mismatch(test, $sformatf("pixel x=%0d y=%0d rgb", x, y), expected, got);
            end
            x++;
         end else begin
            if (got !== 3'b000) report_mismatch(test, "rgb in blanking", 0, got);
            done = de_q && (y == CHECK_LINES - 1);
         end
         de_q = de;
      end
   endtask

   task automatic test_reset();
      @(posedge clk);                            // first edge applies the reset
      while (!arst_n) begin
         @(posedge clk);
         check_idle("test_reset");
      end
      repeat (3) begin                           // pipeline still shows the reset state
         @(posedge clk);
         check_idle("test_reset");
      end
   endtask

   // runs from frame 0 line 0 up to the end of the first vsync pulse
   task automatic test_sync_timing();
      int de_len;
      int hs_len;
      int vs_len;
      int runs;
      int hs_pulses;
      bit done;
      de_len    = 0;
      hs_len    = 0;
      vs_len    = 0;
      runs      = 0;
      hs_pulses = 0;
      done      = 1'b0;
      while (!done) begin
         @(posedge clk);
         if (de) begin
            de_len++;
         end else if (de_len != 0) begin
            if (de_len != H_ACTIVE) begin
               report_mismatch("test_sync_timing", "de run length", H_ACTIVE, de_len);
            end
            runs++;
            de_len = 0;
         end
         if (!hsync) begin
            hs_len++;
         end else if (hs_len != 0) begin
            if (hs_len != H_SYNC) begin
               report_mismatch("test_sync_timing", "hsync pulse length", H_SYNC, hs_len);
            end
            hs_pulses++;
            hs_len = 0;
         end
         if (!vsync) begin
            vs_len++;
         end else if (vs_len != 0) begin
            done = 1'b1;
         end
      end
      if (runs != V_ACTIVE) begin
         report_mismatch("test_sync_timing", "de runs per frame", V_ACTIVE, runs);
      end
      if (hs_pulses != V_ACTIVE + V_FRONT + V_SYNC) begin
         report_mismatch("test_sync_timing", "hsync pulses before vsync end",
                         V_ACTIVE + V_FRONT + V_SYNC, hs_pulses);
      end
      if (vs_len != V_SYNC * H_TOTAL) begin
         report_mismatch("test_sync_timing", "vsync pulse length", V_SYNC * H_TOTAL, vs_len);
      end
   endtask

   task automatic test_pattern_write();
      int   x;
      int   y;
      rgb_t rgb;
      for (int i = 0; i < 200; i++) begin
         x   = next_random() % IMG_W;
         y   = next_random() % 4;                // rows 0 to 3 land in the checked lines
         rgb = next_random() % 8;
         written_x.push_back(x);
         written_y.push_back(y);
         write_pixel(x, y, rgb, 3'b111);
      end
      end_writes();
      check_lines("test_pattern_write");         // still inside vertical blanking
   endtask

   task automatic test_plane_mask();
      logic [2:0] masks [6] = '{3'b100, 3'b010, 3'b001, 3'b110, 3'b101, 3'b011};
      int         k;
      rgb_t       rgb;
      for (int i = 0; i < 60; i++) begin
         k   = next_random() % written_x.size();
         rgb = next_random() % 8;
         write_pixel(written_x[k], written_y[k], rgb, masks[next_random() % 6]);
      end
      end_writes();
      wait_vsync_fall();
      check_lines("test_plane_mask");
   endtask

   task automatic test_out_of_range();
      int x;
      int y;
      for (int i = 0; i < 64; i++) begin
         if (i % 2 == 0) begin
            x = IMG_W + next_random() % 128;     // low bits alias a checked pixel
            y = next_random() % 4;
         end else begin
            x = next_random() % 256;
            y = IMG_H + next_random() % 32;
         end
         write_pixel(x, y, ~model[y % 4][x % IMG_W], 3'b111);   // inverted, so a leak shows
      end
      end_writes();
      wait_vsync_fall();
      check_lines("test_out_of_range");
   endtask

   initial begin
      wr_en   = 1'b0;
      wr_x    = '0;
      wr_y    = '0;
      wr_rgb  = '0;
      wr_mask = '0;
      for (int r = 0; r < IMG_H; r++) begin
         for (int c = 0; c < IMG_W; c++) begin
            model[r][c] = '0;
         end
      end
      test_reset();
      fork
         check_lines("test_reset");              // first frame must be black
         test_sync_timing();
      join
      test_pattern_write();
      test_plane_mask();
      test_out_of_range();
      $display("run finished with %0d errors", errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the tests did not complete", cycle_count);
      $display("run finished with %0d errors", errors);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
fb_pkg.sv
video_timing_if.sv
color_plane_ram.sv
vga_timing_gen.sv
pixel_fetch.sv
fb_write_port.sv
frame_buffer_top.sv
tb_clock_gen.sv
tb_frame_buffer.sv

//--- Bender.yml
package:
  name: frame_buffer

sources:
  - fb_pkg.sv
  - video_timing_if.sv
  - color_plane_ram.sv
  - vga_timing_gen.sv
  - pixel_fetch.sv
  - fb_write_port.sv
  - frame_buffer_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_frame_buffer.sv
